// File: cpu_pkg.sv
package cpu_pkg;

    // operation codes held in bits 5:0 of the instruction word
    typedef enum logic [5:0] {
        OP_NOP    = 6'd0,
        OP_ADD    = 6'd1,
        OP_SUB    = 6'd2,
        OP_AND    = 6'd3,
        OP_OR     = 6'd4,
        OP_XOR    = 6'd5,
        OP_LOADI  = 6'd6,
        OP_LOAD   = 6'd7,
        OP_STORE  = 6'd8,
        OP_CMP    = 6'd9,
        OP_JUMP   = 6'd10,
        OP_BRANCH = 6'd11
    } opcode_e;

    typedef enum logic [1:0] {
        FETCH     = 2'd0,
        EXECUTE   = 2'd1,
        WRITEBACK = 2'd2
    } state_e;

    // one instruction word, msb first
    typedef struct packed {
        logic [15:0] value;
        logic        high;
        logic [2:0]  dest;
        logic [2:0]  src_b;
        logic [2:0]  src_a;
        opcode_e     opcode;
    } instr_t;

    typedef struct packed {
        logic [31:0] address;
        logic [31:0] wdata;
        logic        write;
    } mem_req_t;

    // target is already the next pc, taken or not
    typedef struct packed {
        logic [31:0] result;
        logic        flag;
        logic        take_jump;
        logic [31:0] target;
    } alu_out_t;

endpackage

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clock,
    input  logic        rst,
    input  logic [2:0]  read_a,
    input  logic [2:0]  read_b,
    input  logic [2:0]  flag_sel_a,
    input  logic        reg_write,
    input  logic        flag_write,
    input  logic [2:0]  write_sel,
    input  logic [31:0] write_data,
    input  logic        write_flag,
    output logic [31:0] data_a,
    output logic [31:0] data_b,
    output logic        flag_a
);

    logic [31:0] regs [8];
    logic        flags [8];

    // combinational read ports
    assign data_a = regs[read_a];
    assign data_b = regs[read_b];
    assign flag_a = flags[flag_sel_a];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
            begin
                regs[i]  <= '0;
                flags[i] <= 1'b0;
            end
        end
        else
        begin
            if (reg_write)
            begin
                regs[write_sel] <= write_data;
            end
            // flag shares the destination index with the register
            if (flag_write)
            begin
                flags[write_sel] <= write_flag;
            end
        end
    end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::instr_t   instr,
    input  logic [31:0]       data_a,
    input  logic [31:0]       data_b,
    input  logic [31:0]       dest_value,
    input  logic              flag_a,
    input  logic [31:0]       pc,
    output cpu_pkg::alu_out_t out
);

    logic [31:0] imm;
    logic        is_logic_op;

    assign imm = {16'b0, instr.value};

    assign is_logic_op = instr.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                                              cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                                              cpu_pkg::OP_XOR};

    always_comb
    begin
        out.result    = '0;
        out.flag      = 1'b0;
        out.take_jump = 1'b0;
        case (instr.opcode)
            cpu_pkg::OP_ADD:    out.result = data_a + data_b;
            cpu_pkg::OP_SUB:    out.result = data_a - data_b;
            cpu_pkg::OP_AND:    out.result = data_a & data_b;
            cpu_pkg::OP_OR:     out.result = data_a | data_b;
            cpu_pkg::OP_XOR:    out.result = data_a ^ data_b;
            cpu_pkg::OP_LOADI:
            begin
                // high half keeps the low half of the destination
                if (instr.high)
                begin
                    out.result = {instr.value, dest_value[15:0]};
                end
                else
                begin
                    out.result = imm;
                end
            end
            cpu_pkg::OP_CMP:    out.flag = (data_a == data_b);
            cpu_pkg::OP_JUMP:   out.take_jump = 1'b1;
            cpu_pkg::OP_BRANCH: out.take_jump = flag_a;
            default:            out.result = '0;
        endcase

        if (is_logic_op)
        begin
            out.flag = (out.result == 32'd0);
        end

        out.target = out.take_jump ? imm : pc + 32'd1;
    end

endmodule

// File: sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic             clock,
    input  logic             rst,
    input  logic [31:0]      rdata,
    input  logic             take_jump,
    input  logic [31:0]      target,
    output cpu_pkg::state_e  state,
    output logic [31:0]      pc,
    output cpu_pkg::instr_t  instr
);

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state <= cpu_pkg::FETCH;
            pc    <= '0;
            instr <= '0;
        end
        else
        begin
            case (state)
                cpu_pkg::FETCH:
                begin
                    instr <= cpu_pkg::instr_t'(rdata);
                    state <= cpu_pkg::EXECUTE;
                end
                cpu_pkg::EXECUTE:
                begin
                    state <= cpu_pkg::WRITEBACK;
                end
                cpu_pkg::WRITEBACK:
                begin
                    // sequential step unless a jump or taken branch
                    if (take_jump)
                    begin
                        pc <= target;
                    end
                    else
                    begin
                        pc <= pc + 32'd1;
                    end
                    state <= cpu_pkg::FETCH;
                end
                default:
                begin
                    state <= cpu_pkg::FETCH;
                end
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge clock) disable iff (rst)
        state inside {cpu_pkg::FETCH, cpu_pkg::EXECUTE, cpu_pkg::WRITEBACK}
    );

    // pc holds through fetch and execute
    a_pc_only_in_writeback: assert property (
        @(posedge clock) disable iff (rst)
        (state != cpu_pkg::WRITEBACK) |=> $stable(pc)
    );

endmodule

// File: cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic               clock,
    input  logic               rst,
    input  logic [31:0]        rdata,
    output cpu_pkg::mem_req_t  mem_req
);

    cpu_pkg::state_e   state;
    cpu_pkg::instr_t   instr;
    cpu_pkg::alu_out_t alu_out;
    logic [31:0]       pc;
    logic [31:0]       data_a;
    logic [31:0]       data_b;
    logic              flag_a;
    logic [2:0]        read_b_sel;
    logic              reg_write;
    logic              flag_write;
    logic [31:0]       write_data;
    logic [31:0]       load_reg;
    logic              is_mem_op;

    sequencer u_sequencer (
        .clock     (clock),
        .rst       (rst),
        .rdata     (rdata),
        .take_jump (alu_out.take_jump),
        .target    (alu_out.target),
        .state     (state),
        .pc        (pc),
        .instr     (instr)
    );

    // loadi high reads its own destination through port b
    assign read_b_sel = (instr.opcode == cpu_pkg::OP_LOADI) ? instr.dest : instr.src_b;

    reg_file u_reg_file (
        .clock      (clock),
        .rst        (rst),
        .read_a     (instr.src_a),
        .read_b     (read_b_sel),
        .flag_sel_a (instr.src_a),
        .reg_write  (reg_write),
        .flag_write (flag_write),
        .write_sel  (instr.dest),
        .write_data (write_data),
        .write_flag (alu_out.flag),
        .data_a     (data_a),
        .data_b     (data_b),
        .flag_a     (flag_a)
    );

    alu u_alu (
        .instr      (instr),
        .data_a     (data_a),
        .data_b     (data_b),
        .dest_value (data_b),
        .flag_a     (flag_a),
        .pc         (pc),
        .out        (alu_out)
    );

    assign reg_write = (state == cpu_pkg::WRITEBACK) &&
                       (instr.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                                             cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                                             cpu_pkg::OP_XOR, cpu_pkg::OP_LOADI,
                                             cpu_pkg::OP_LOAD});

    assign flag_write = (state == cpu_pkg::WRITEBACK) &&
                        (instr.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                                              cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                                              cpu_pkg::OP_XOR, cpu_pkg::OP_CMP});

    assign write_data = (instr.opcode == cpu_pkg::OP_LOAD) ? load_reg : alu_out.result;

    // memory word for load is captured in execute, written back next cycle
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::EXECUTE && instr.opcode == cpu_pkg::OP_LOAD)
        begin
            load_reg <= rdata;
        end
    end

    assign is_mem_op = (state == cpu_pkg::EXECUTE) &&
                       (instr.opcode inside {cpu_pkg::OP_LOAD, cpu_pkg::OP_STORE});

    assign mem_req.address = is_mem_op ? {16'b0, instr.value} : pc;
    assign mem_req.wdata   = data_a;
    assign mem_req.write   = (state == cpu_pkg::EXECUTE) &&
                             (instr.opcode == cpu_pkg::OP_STORE);

    // a store always follows the fetch of a store word directly
    a_write_only_store: assert property (
        @(posedge clock) disable iff (rst)
        mem_req.write |-> ($past(state) == cpu_pkg::FETCH) &&
                          ($past(rdata[5:0]) == cpu_pkg::OP_STORE)
    );

endmodule

// File: unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clock,
    input  cpu_pkg::mem_req_t  mem_req,
    output logic [31:0]        rdata,
    input  logic               load_write,
    input  logic [31:0]        load_address,
    input  logic [31:0]        load_data
);

    localparam int ADDR_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [31:0]       mem [MEM_WORDS];
    logic [31:0]       req_mod;
    logic [31:0]       load_mod;
    logic [ADDR_W-1:0] req_index;
    logic [ADDR_W-1:0] load_index;

    // addresses wrap at the memory size, which need not be a power of two
    assign req_mod    = mem_req.address % MEM_WORDS;
    assign load_mod   = load_address % MEM_WORDS;
    assign req_index  = req_mod[ADDR_W-1:0];
    assign load_index = load_mod[ADDR_W-1:0];

    assign rdata = mem[req_index];

    always_ff @(posedge clock)
    begin
        if (load_write)
            mem[load_index] <= load_data;
        else if (mem_req.write)
            mem[req_index] <= mem_req.wdata;
    end

    // boot loading happens only while the core sits in reset
    a_load_during_reset: assert property (
        @(posedge clock) load_write |-> !mem_req.write
    );

endmodule

// File: cpu_system.sv
`timescale 1ns/1ps

module cpu_system #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               load_write,
    input  logic [31:0]        load_address,
    input  logic [31:0]        load_data,
    output cpu_pkg::mem_req_t  mem_req
);

    logic [31:0] rdata;

    cpu_core u_core (
        .clock   (clock),
        .rst     (rst),
        .rdata   (rdata),
        .mem_req (mem_req)
    );

    // program and data share this one memory
    unified_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_memory (
        .clock        (clock),
        .mem_req      (mem_req),
        .rdata        (rdata),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data)
    );

endmodule

// File: tb_cpu_system.sv
`timescale 1ns/1ps

module tb_cpu_system;

    localparam int          MEM_WORDS = 256;
    localparam int          DATA_ADDR = 200;
    localparam logic [31:0] SEED      = 32'hf4fb_999f;

    logic              clock;
    logic              rst;
    logic              load_write;
    logic [31:0]       load_address;
    logic [31:0]       load_data;
    cpu_pkg::mem_req_t mem_req;

    // program and data image, also the memory of the reference model
    logic [31:0] prog [MEM_WORDS];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    int  prog_len;
    int  exp_count;
    int  first_k;
    int  instr_count;
    int  halt_pc;
    int  store_index;
    int  cycle_count;
    int  halt_cycles;
    int  errors;
    int  passed;
    int  failed;
    time deadline;

    cpu_system #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clock        (clock),
        .rst          (rst),
        .load_write   (load_write),
        .load_address (load_address),
        .load_data    (load_data),
        .mem_req      (mem_req)
    );

    always #10 clock = ~clock;

    task automatic emit(cpu_pkg::opcode_e op, int a, int b, int d, logic high,
                        logic [15:0] value);
        cpu_pkg::instr_t w;
        w.opcode = op;
        w.src_a  = 3'(a);
        w.src_b  = 3'(b);
        w.dest   = 3'(d);
        w.high   = high;
        w.value  = value;
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program(logic [31:0] x, logic [31:0] y, logic [31:0] word);
        prog_len = 0;
        emit(cpu_pkg::OP_LOADI, 0, 0, 1, 1'b0, x[15:0]);
        emit(cpu_pkg::OP_LOADI, 0, 0, 1, 1'b1, x[31:16]);
        emit(cpu_pkg::OP_LOADI, 0, 0, 2, 1'b0, y[15:0]);
        emit(cpu_pkg::OP_LOADI, 0, 0, 2, 1'b1, y[31:16]);
        emit(cpu_pkg::OP_LOADI, 0, 0, 5, 1'b0, 16'hbeef);
        // add, sub, and, or, xor of r1 and r2, each one stored
        for (int i = 0; i < 5; i++)
        begin
            emit(cpu_pkg::opcode_e'(cpu_pkg::OP_ADD + i), 1, 2, 3, 1'b0, 16'd0);
            emit(cpu_pkg::OP_STORE, 3, 0, 0, 1'b0, 16'(100 + i));
        end
        emit(cpu_pkg::OP_SUB, 1, 1, 4, 1'b0, 16'd0);
        emit(cpu_pkg::OP_BRANCH, 4, 0, 0, 1'b0, 16'd18);
        emit(cpu_pkg::OP_STORE, 5, 0, 0, 1'b0, 16'd110);
        emit(cpu_pkg::OP_CMP, 1, 2, 6, 1'b0, 16'd0);
        emit(cpu_pkg::OP_BRANCH, 6, 0, 0, 1'b0, 16'd21);
        emit(cpu_pkg::OP_STORE, 5, 0, 0, 1'b0, 16'd111);
        emit(cpu_pkg::OP_JUMP, 0, 0, 0, 1'b0, 16'd24);
        emit(cpu_pkg::OP_STORE, 1, 0, 0, 1'b0, 16'd120);
        emit(cpu_pkg::OP_STORE, 2, 0, 0, 1'b0, 16'd121);
        emit(cpu_pkg::OP_LOAD, 0, 0, 6, 1'b0, 16'(DATA_ADDR));
        emit(cpu_pkg::OP_LOADI, 0, 0, 7, 1'b0, 16'h0123);
        emit(cpu_pkg::OP_ADD, 6, 7, 7, 1'b0, 16'd0);
        emit(cpu_pkg::OP_STORE, 7, 0, 0, 1'b0, 16'd130);
        // halt loop
        emit(cpu_pkg::OP_JUMP, 0, 0, 0, 1'b0, 16'(prog_len));
        prog[DATA_ADDR] = word;
    endtask

    // instruction level model, one instruction per step
    task automatic run_model();
        logic [31:0]     r [8];
        logic            f [8];
        logic [31:0]     mem [MEM_WORDS];
        cpu_pkg::instr_t ir;
        int              pc;
        int              npc;
        mem = prog;
        for (int i = 0; i < 8; i++)
        begin
            r[i] = 32'd0;
            f[i] = 1'b0;
        end
        pc = 0;
        exp_count = 0;
        instr_count = 0;
        while (instr_count < 500)
        begin
            ir = cpu_pkg::instr_t'(mem[pc]);
            instr_count++;
            npc = pc + 1;
            case (ir.opcode)
                cpu_pkg::OP_ADD: r[ir.dest] = r[ir.src_a] + r[ir.src_b];
                cpu_pkg::OP_SUB: r[ir.dest] = r[ir.src_a] - r[ir.src_b];
                cpu_pkg::OP_AND: r[ir.dest] = r[ir.src_a] & r[ir.src_b];
                cpu_pkg::OP_OR:  r[ir.dest] = r[ir.src_a] | r[ir.src_b];
                cpu_pkg::OP_XOR: r[ir.dest] = r[ir.src_a] ^ r[ir.src_b];
                cpu_pkg::OP_LOADI:
                    r[ir.dest] = ir.high ? {ir.value, r[ir.dest][15:0]} : {16'h0, ir.value};
                cpu_pkg::OP_LOAD: r[ir.dest] = mem[int'(ir.value) % MEM_WORDS];
                cpu_pkg::OP_STORE:
                begin
                    mem[int'(ir.value) % MEM_WORDS] = r[ir.src_a];
                    exp_addr[exp_count] = {16'h0, ir.value};
                    exp_data[exp_count] = r[ir.src_a];
                    if (exp_count == 0)
                        first_k = instr_count;
                    exp_count++;
                end
                cpu_pkg::OP_CMP:    f[ir.dest] = (r[ir.src_a] == r[ir.src_b]);
                cpu_pkg::OP_JUMP:   npc = int'(ir.value);
                cpu_pkg::OP_BRANCH: npc = f[ir.src_a] ? int'(ir.value) : npc;
                default:            npc = pc + 1;
            endcase
            if (ir.opcode inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                                  cpu_pkg::OP_OR, cpu_pkg::OP_XOR})
                f[ir.dest] = (r[ir.dest] == 32'd0);
            if (npc == pc)
                break;
            pc = npc;
        end
        halt_pc = pc;
    endtask

    task automatic load_word(int address, logic [31:0] data);
        @(posedge clock);
        #1;
        load_write   = 1'b1;
        load_address = 32'(address);
        load_data    = data;
    endtask

    task automatic run_test(string name, logic [31:0] x, logic [31:0] y, logic [31:0] word);
        int errors_before;
        errors_before = errors;
        @(posedge clock);
        #1;
        rst = 1'b1;
        build_program(x, y, word);
        run_model();
        deadline = $time + 64'((prog_len + 30) * 20);
        repeat (10) @(posedge clock);
        for (int i = 0; i < prog_len; i++)
            load_word(i, prog[i]);
        load_word(DATA_ADDR, prog[DATA_ADDR]);
        @(posedge clock);
        #1;
        load_write = 1'b0;
        rst = 1'b0;
        deadline = $time + 64'((instr_count * 3 + 20) * 20);
        // done once every store is seen and the halt loop has run twice
        wait (store_index == exp_count && halt_cycles >= 6);
        if (errors == errors_before)
            passed++;
        else
            failed++;
        $display("%s: %0d stores over %0d instructions, %s", name, exp_count, instr_count,
                 (errors == errors_before) ? "ok" : "errors seen");
    endtask

    always @(posedge clock)
    begin
        if (rst)
        begin
            store_index <= 0;
            cycle_count <= 0;
            halt_cycles <= 0;
        end
        else
        begin
            cycle_count <= cycle_count + 1;
            if (mem_req.write)
                store_index <= store_index + 1;
            if (mem_req.address == 32'(halt_pc))
                halt_cycles <= halt_cycles + 1;
        end
    end

    a_idle_in_reset: assert property (@(posedge clock) rst |=> !mem_req.write)
    else
    begin
        $display("FAILED t=%0t mem_req.write expected %b got %b", $time, 1'b0,
                 $sampled(mem_req.write));
        errors++;
    end

    a_first_fetch: assert property (@(posedge clock) $fell(rst) |-> mem_req.address == 32'd0)
    else
    begin
        $display("FAILED t=%0t mem_req.address expected %h got %h", $time, 32'd0,
                 $sampled(mem_req.address));
        errors++;
    end

    a_store_expected: assert property (@(posedge clock) disable iff (rst)
        mem_req.write |-> store_index < exp_count)
    else
    begin
        $display("unexpected store to address %0d at %0t", $sampled(mem_req.address), $time);
        errors++;
    end

    a_store_address: assert property (@(posedge clock) disable iff (rst)
        mem_req.write && store_index < exp_count |-> mem_req.address == exp_addr[store_index])
    else
    begin
        $display("FAILED t=%0t mem_req.address expected %h got %h", $time,
                 exp_addr[$sampled(store_index)], $sampled(mem_req.address));
        errors++;
    end

    a_store_data: assert property (@(posedge clock) disable iff (rst)
        mem_req.write && store_index < exp_count |-> mem_req.wdata == exp_data[store_index])
    else
    begin
        $display("FAILED t=%0t mem_req.wdata expected %h got %h", $time,
                 exp_data[$sampled(store_index)], $sampled(mem_req.wdata));
        errors++;
    end

    // first store lands in cycle 3k-2 counted from reset release
    a_store_timing: assert property (@(posedge clock) disable iff (rst)
        mem_req.write && store_index == 0 |-> cycle_count == 3 * first_k - 2)
    else
    begin
        $display("FAILED t=%0t cycle_count expected %0d got %0d", $time, 3 * first_k - 2,
                 $sampled(cycle_count));
        errors++;
    end

    a_write_gap: assert property (@(posedge clock) disable iff (rst)
        $past(mem_req.write) || $past(mem_req.write, 2) |-> !mem_req.write)
    else
    begin
        $display("a write came less than three cycles after the previous one at %0t", $time);
        errors++;
    end

    always @(posedge clock)
    begin
        if ($time > deadline)
        begin
            $display("timeout: the program did not reach its halt loop in time");
            $display("Test failures found");
            $finish;
        end
    end

    initial
    begin
        clock        = 1'b0;
        rst          = 1'b1;
        load_write   = 1'b0;
        load_address = 32'd0;
        load_data    = 32'd0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        exp_count    = 0;
        first_k      = 1;
        halt_pc      = 0;
        deadline     = 64'd2000;
        void'($urandom(SEED));
        run_test("fixed operands", 32'h1234_5678, 32'h0f0f_00ff, 32'h0000_1000);
        run_test("random operands", $urandom, $urandom, $urandom);
        $display("tests passed: %0d, tests failed: %0d", passed, failed);
        if (failed == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: all.f
cpu_pkg.sv
reg_file.sv
alu.sv
sequencer.sv
cpu_core.sv
unified_memory.sv
cpu_system.sv
tb_cpu_system.sv

// File: Makefile
TOP = tb_cpu_system

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
